/* tetris_core.f */
+incdir+include
logic/tetris_pkg.sv
logic/piece_spawner.sv
logic/move_resolver.sv
logic/line_clear.sv
logic/tetris_fsm.sv
logic/tetris_core.sv
verif/tetris_sva.sv
verif/tb_tetris.sv

/* verif/tetris_vectors.txt */
# name command n value(hex)
# move: n repeats of code value; row: n is the row, value has col 9 in the top bits
# start: n and value unused; lines and over: value is the expected count or flag
spawn_t start 1 0
spawn_t_r0 row 0 00001000
spawn_t_r1 row 1 00009200
shift_r move 1 0
shift_r_r1 row 1 00049000
wall_r move 4 0
wall_r_r1 row 1 09200000
rol_t move 1 3
rol_t_r1 row 1 01200000
shift_r2 move 1 0
ror_blk move 1 2
ror_blk_r1 row 1 09000000
ror_blk_r2 row 2 08000000
shift_l move 1 1
ror_t move 1 2
ror_t_r1 row 1 09200000
drop_t move 19 4
lock_t_r19 row 19 09200000
spawn_j_r1 row 1 00012400
wall_l move 4 1
wall_l_r1 row 1 00000092
drop_j move 19 4
ror_l move 1 2
shift_l_r move 1 0
ror_l_r2 row 2 000d8000
drop_l move 18 4
shift_o move 1 1
drop_o move 19 4
clear_lines lines 0 1
clear_r19 row 19 0101c802
clear_r18 row 18 00018000
spawn_s_r0 row 0 0002d000
stack_a move 48 4
stack_a_r14 row 14 001ffe00
stack_b move 49 4
over_set over 0 1
over_r1 row 1 001ffe00
restart start 1 0
restart_over over 0 0
restart_lines lines 0 0
restart_r19 row 19 00000000
restart_r0 row 0 00000400

/* verif/tb_tetris.sv */
`include "tetris_config.svh"

module tb_tetris;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period        = 100;
  localparam int drive_delay       = 10;
  localparam int reset_cycles      = 4;
  // lock plus row walk plus respawn stays well under this
  localparam int busy_limit        = 60;
  localparam int cycles_per_vector = 40;
  localparam string vector_file    = "verif/tetris_vectors.txt";

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic                   move_strobe;
  tetris_pkg::move_code_t move_code;
  tetris_pkg::board_t     board;
  logic                   busy;
  logic                   game_over;
  logic [15:0]            lines;

  // parsed vector lines
  string       vec_name[$];
  string       vec_cmd[$];
  int          vec_n[$];
  logic [31:0] vec_value[$];
  // commands after expanding move repeats
  int          vec_total;
  logic        loaded;
  int          errors;
  int          checks;

  tetris_core dut (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .move_strobe (move_strobe),
    .move_code   (move_code),
    .board       (board),
    .busy        (busy),
    .game_over   (game_over),
    .lines       (lines)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // vector file
  //////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       cmd;
    int          count;
    logic [31:0] value;
    fd = $fopen(vector_file, "r");
    if (fd == 0) begin
      $display("cannot open vector file %s", vector_file);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comment lines
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %s %d %h", name, cmd, count, value);
        if (n == 4) begin
          vec_name.push_back(name);
          vec_cmd.push_back(cmd);
          vec_n.push_back(count);
          vec_value.push_back(value);
          vec_total += (cmd == "move") ? count : 1;
        end else if (n > 0) begin
          $display("malformed vector line: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // drive and compare
  //////////////////////////////

  // busy falls when the step is over, game over holds it high
  task automatic wait_idle(input string name);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < busy_limit) begin
      @(negedge clk);
      cycles++;
      if (!busy || game_over) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("%s: busy did not fall within %0d cycles", name, busy_limit);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  // one strobe, captured on exactly one edge
  task automatic pulse_input(input logic is_move, input tetris_pkg::move_code_t code);
    @(posedge clk);
    #(drive_delay);
    if (is_move) begin
      move_code   = code;
      move_strobe = 1'b1;
    end else begin
      start = 1'b1;
    end
    @(posedge clk);
    #(drive_delay);
    move_strobe = 1'b0;
    start       = 1'b0;
  endtask

  task automatic run_vector(input int i);
    string name;
    name = vec_name[i];
    if (vec_cmd[i] == "start") begin
      pulse_input(1'b0, '0);
      wait_idle(name);
    end else if (vec_cmd[i] == "move") begin
      for (int k = 0; k < vec_n[i]; k++) begin
        pulse_input(1'b1, tetris_pkg::move_code_t'(vec_value[i]));
        wait_idle(name);
      end
    end else if (vec_cmd[i] == "row") begin
      if (vec_n[i] < 0 || vec_n[i] >= `TETRIS_ROWS) begin
        $display("%s: row %0d is outside the board", name, vec_n[i]);
        errors++;
      end else begin
        check_value(name, vec_value[i], {2'b00, board[vec_n[i]]});
      end
    end else if (vec_cmd[i] == "lines") begin
      check_value(name, vec_value[i], {16'h0000, lines});
    end else if (vec_cmd[i] == "over") begin
      check_value(name, vec_value[i], {31'h0, game_over});
    end else begin
      $display("%s: unknown command %s", name, vec_cmd[i]);
      errors++;
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    move_strobe = 1'b0;
    move_code   = '0;
    errors      = 0;
    checks      = 0;
    vec_total   = 0;
    loaded      = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst = 1'b0;
    // idle after reset
    @(negedge clk);
    check_value("reset_busy", 32'd1, {31'h0, busy});
    check_value("reset_over", 32'd0, {31'h0, game_over});
    check_value("reset_lines", 32'd0, {16'h0000, lines});
    check_value("reset_board", 32'd0, {31'h0, |board});
    for (int i = 0; i < vec_name.size(); i++) begin
      run_vector(i);
    end
    @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 4) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // budget scales with the expanded command count
  initial begin
    wait (loaded === 1'b1);
    #((vec_total + reset_cycles) * cycles_per_vector * clk_period);
    $display("watchdog expired after %0d cycles, run did not finish",
             (vec_total + reset_cycles) * cycles_per_vector);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verif/tetris_sva.sv */
module tetris_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   start,
  input tetris_pkg::fsm_state_e state,
  input logic                   spawn_req,
  input logic                   check_req,
  input logic                   check_done,
  input logic                   clear_start,
  input logic                   busy,
  input logic                   game_over,
  input logic [15:0]            lines
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // request pulses
  //////////////////////////////

  spawn_pulse: assert property (@(posedge clk) disable iff (rst) spawn_req |=> !spawn_req)
    else $error("spawn_req high for more than one cycle");

  check_pulse: assert property (@(posedge clk) disable iff (rst) check_req |=> !check_req)
    else $error("check_req high for more than one cycle");

  clear_pulse: assert property (@(posedge clk) disable iff (rst) clear_start |=> !clear_start)
    else $error("clear_start high for more than one cycle");

  // verdict exactly one cycle after the request
  done_follows_req: assert property (@(posedge clk) disable iff (rst) check_req |=> check_done)
    else $error("check_done missing one cycle after check_req");

  done_has_req: assert property (@(posedge clk) disable iff (rst)
    check_done |-> $past(check_req))
    else $error("check_done without a check_req one cycle before");

  //////////////////////////////
  // state invariants
  //////////////////////////////

  // spawn, verdict, clear and game over all happen outside READY
  busy_outside_ready: assert property (@(posedge clk) disable iff (rst)
    (spawn_req || check_req || check_done || clear_start || game_over) |-> busy)
    else $error("busy low while the controller is working");

  // only a restart may bring the count back
  lines_monotonic: assert property (@(posedge clk) disable iff (rst)
    lines < $past(lines) |-> $past(state) == tetris_pkg::GAME_OVER && $past(start))
    else $error("line count decreased without a restart");

endmodule

bind tetris_fsm tetris_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .start       (start),
  .state       (state),
  .spawn_req   (spawn_req),
  .check_req   (check_req),
  .check_done  (check_done),
  .clear_start (clear_start),
  .busy        (busy),
  .game_over   (game_over),
  .lines       (lines)
);

/* logic/tetris_core.sv */
module tetris_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   move_strobe,
  input  tetris_pkg::move_code_t move_code,
  output tetris_pkg::board_t     board,
  output logic                   busy,
  output logic                   game_over,
  output logic [15:0]            lines
);

  //////////////////////////////
  // internal links
  //////////////////////////////

  // spawner
  logic                   spawn_req;
  tetris_pkg::piece_pos_s spawn_pos;
  tetris_pkg::color_t     spawn_color;
  // resolver
  tetris_pkg::piece_pos_s cur_pos;
  tetris_pkg::cell_set_s  cur_cells;
  logic                   check_req;
  tetris_pkg::move_code_t check_code;
  tetris_pkg::board_t     settled;
  logic                   check_done;
  logic                   check_ok;
  tetris_pkg::piece_pos_s cand_pos;
  // line clearer
  logic                   clear_start;
  logic                   clear_done;
  tetris_pkg::board_t     cleared_board;
  logic [2:0]             clear_count;

  tetris_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .move_strobe   (move_strobe),
    .move_code     (move_code),
    .spawn_pos     (spawn_pos),
    .spawn_color   (spawn_color),
    .spawn_req     (spawn_req),
    .cur_pos       (cur_pos),
    .cur_cells     (cur_cells),
    .check_req     (check_req),
    .check_code    (check_code),
    .settled       (settled),
    .check_done    (check_done),
    .check_ok      (check_ok),
    .cand_pos      (cand_pos),
    .clear_start   (clear_start),
    .clear_done    (clear_done),
    .cleared_board (cleared_board),
    .clear_count   (clear_count),
    .board         (board),
    .busy          (busy),
    .game_over     (game_over),
    .lines         (lines)
  );

  piece_spawner u_spawner (
    .clk         (clk),
    .rst         (rst),
    .spawn_req   (spawn_req),
    .spawn_pos   (spawn_pos),
    .spawn_color (spawn_color)
  );

  move_resolver u_resolver (
    .clk        (clk),
    .rst        (rst),
    .cur_pos    (cur_pos),
    .cur_cells  (cur_cells),
    .check_req  (check_req),
    .check_code (check_code),
    .settled    (settled),
    .check_done (check_done),
    .check_ok   (check_ok),
    .cand_pos   (cand_pos)
  );

  line_clear u_clear (
    .clk           (clk),
    .rst           (rst),
    .clear_start   (clear_start),
    .board_in      (settled),
    .cleared_board (cleared_board),
    .clear_done    (clear_done),
    .clear_count   (clear_count)
  );

endmodule

/* logic/tetris_fsm.sv */
`include "tetris_config.svh"

module tetris_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   move_strobe,
  input  tetris_pkg::move_code_t move_code,
  input  tetris_pkg::piece_pos_s spawn_pos,
  input  tetris_pkg::color_t     spawn_color,
  output logic                   spawn_req,
  output tetris_pkg::piece_pos_s cur_pos,
  input  tetris_pkg::cell_set_s  cur_cells,
  output logic                   check_req,
  output tetris_pkg::move_code_t check_code,
  output tetris_pkg::board_t     settled,
  input  logic                   check_done,
  input  logic                   check_ok,
  input  tetris_pkg::piece_pos_s cand_pos,
  output logic                   clear_start,
  input  logic                   clear_done,
  input  tetris_pkg::board_t     cleared_board,
  input  logic [2:0]             clear_count,
  output tetris_pkg::board_t     board,
  output logic                   busy,
  output logic                   game_over,
  output logic [15:0]            lines
);

  tetris_pkg::fsm_state_e state;
  tetris_pkg::color_t     cur_color;
  logic                   spawn_hit;
  logic                   piece_live;

  // one cycle in SPAWN, so this is a single pulse
  assign spawn_req  = (state == tetris_pkg::SPAWN);
  assign busy       = (state != tetris_pkg::READY);
  // piece drawn from first READY until its cells are written into the board
  assign piece_live = (state == tetris_pkg::READY) || (state == tetris_pkg::RESOLVE) ||
                      (state == tetris_pkg::LOCK);

  // spawn cells already taken
  always_comb begin
    spawn_hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (settled[cur_cells.row[i]][cur_cells.col[i]] != '0) begin
        spawn_hit = 1'b1;
      end
    end
  end

  // display overlay
  always_comb begin
    board = settled;
    if (piece_live) begin
      for (int i = 0; i < 4; i++) begin
        board[cur_cells.row[i]][cur_cells.col[i]] = cur_color;
      end
    end
  end

  //////////////////////////////
  // controller
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= tetris_pkg::IDLE;
      settled     <= '0;
      cur_pos     <= '0;
      cur_color   <= '0;
      lines       <= '0;
      game_over   <= 1'b0;
      check_req   <= 1'b0;
      check_code  <= '0;
      clear_start <= 1'b0;
    end else begin
      check_req   <= 1'b0;
      clear_start <= 1'b0;
      case (state)
        tetris_pkg::IDLE: begin
          if (start) begin
            cur_pos   <= spawn_pos;
            cur_color <= spawn_color;
            state     <= tetris_pkg::SPAWN;
          end
        end
        tetris_pkg::SPAWN: begin
          if (spawn_hit) begin
            game_over <= 1'b1;
            state     <= tetris_pkg::GAME_OVER;
          end else begin
            state <= tetris_pkg::READY;
          end
        end
        tetris_pkg::READY: begin
          // code held for the verdict cycle
          if (move_strobe) begin
            check_req  <= 1'b1;
            check_code <= move_code;
            state      <= tetris_pkg::RESOLVE;
          end
        end
        tetris_pkg::RESOLVE: begin
          if (check_done) begin
            if (check_ok) begin
              cur_pos <= cand_pos;
              state   <= tetris_pkg::READY;
            end else if (check_code == `TETRIS_MV_DOWN) begin
              state <= tetris_pkg::LOCK;
            end else begin
              state <= tetris_pkg::READY;
            end
          end
        end
        tetris_pkg::LOCK: begin
          // freeze piece into the board, clearer copies it next cycle
          for (int i = 0; i < 4; i++) begin
            settled[cur_cells.row[i]][cur_cells.col[i]] <= cur_color;
          end
          clear_start <= 1'b1;
          state       <= tetris_pkg::CLEAR;
        end
        tetris_pkg::CLEAR: begin
          if (clear_done) begin
            settled   <= cleared_board;
            lines     <= lines + 16'(clear_count);
            cur_pos   <= spawn_pos;
            cur_color <= spawn_color;
            state     <= tetris_pkg::SPAWN;
          end
        end
        tetris_pkg::GAME_OVER: begin
          // restart, piece order carries on
          if (start) begin
            settled   <= '0;
            lines     <= '0;
            game_over <= 1'b0;
            cur_pos   <= spawn_pos;
            cur_color <= spawn_color;
            state     <= tetris_pkg::SPAWN;
          end
        end
        default: state <= tetris_pkg::IDLE;
      endcase
    end
  end

endmodule

/* logic/line_clear.sv */
`include "tetris_config.svh"

module line_clear (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear_start,
  input  tetris_pkg::board_t board_in,
  output tetris_pkg::board_t cleared_board,
  output logic               clear_done,
  output logic [2:0]         clear_count
);

  // snapshot taken at start, and the compacted result
  tetris_pkg::board_t src_q;
  tetris_pkg::board_t dst_q;
  // read row walks bottom to top, write row trails it
  tetris_pkg::row_t   rd_row;
  tetris_pkg::row_t   wr_row;
  logic [2:0]         drop_cnt;
  logic               active;
  logic               row_full;

  // every cell of the row under the read pointer occupied
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < `TETRIS_COLS; c++) begin
      if (src_q[rd_row][c] == '0) begin
        row_full = 1'b0;
      end
    end
  end

  //////////////////////////////
  // row walk
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active     <= 1'b0;
      clear_done <= 1'b0;
      rd_row     <= '0;
      wr_row     <= '0;
      drop_cnt   <= '0;
    end else begin
      clear_done <= 1'b0;
      if (clear_start) begin
        active   <= 1'b1;
        rd_row   <= tetris_pkg::row_t'(`TETRIS_ROWS - 1);
        wr_row   <= tetris_pkg::row_t'(`TETRIS_ROWS - 1);
        drop_cnt <= '0;
      end else if (active) begin
        rd_row <= rd_row - tetris_pkg::row_t'(1);
        // full row skipped, kept row moves the write pointer up
        if (row_full) begin
          drop_cnt <= drop_cnt + 3'd1;
        end else begin
          wr_row <= wr_row - tetris_pkg::row_t'(1);
        end
        // top row done, pulse next cycle
        if (rd_row == '0) begin
          active     <= 1'b0;
          clear_done <= 1'b1;
        end
      end
    end
  end

  // rows never written stay empty at the top
  always_ff @(posedge clk) begin
    if (clear_start) begin
      src_q <= board_in;
      dst_q <= '0;
    end else if (active && !row_full) begin
      dst_q[wr_row] <= src_q[rd_row];
    end
  end

  assign cleared_board = dst_q;
  assign clear_count   = drop_cnt;

endmodule

/* logic/move_resolver.sv */
`include "tetris_config.svh"

module move_resolver (
  input  logic                   clk,
  input  logic                   rst,
  input  tetris_pkg::piece_pos_s cur_pos,
  output tetris_pkg::cell_set_s  cur_cells,
  input  logic                   check_req,
  input  tetris_pkg::move_code_t check_code,
  input  tetris_pkg::board_t     settled,
  output logic                   check_done,
  output logic                   check_ok,
  output tetris_pkg::piece_pos_s cand_pos
);

  //////////////////////////////
  // shape table
  //////////////////////////////

  // four cells per entry, one hex digit each, digit = box_row*4 + box_col
  // order T J L O S Z I, rotations clockwise from spawn
  function automatic logic [15:0] shape_cells(tetris_pkg::piece_id_t id, tetris_pkg::rot_t rot);
    logic [15:0] s;
    case ({id, rot})
      5'd0:  s = 16'h1456;
      5'd1:  s = 16'h1569;
      5'd2:  s = 16'h4569;
      5'd3:  s = 16'h1459;
      5'd4:  s = 16'h0456;
      5'd5:  s = 16'h1259;
      5'd6:  s = 16'h456A;
      5'd7:  s = 16'h1589;
      5'd8:  s = 16'h2456;
      5'd9:  s = 16'h159A;
      5'd10: s = 16'h4568;
      5'd11: s = 16'h0159;
      // square looks the same in every orientation
      5'd12, 5'd13, 5'd14, 5'd15: s = 16'h1256;
      5'd16: s = 16'h1245;
      5'd17: s = 16'h156A;
      5'd18: s = 16'h5689;
      5'd19: s = 16'h0459;
      5'd20: s = 16'h0156;
      5'd21: s = 16'h2569;
      5'd22: s = 16'h459A;
      5'd23: s = 16'h1458;
      5'd24: s = 16'h4567;
      5'd25: s = 16'h26AE;
      5'd26: s = 16'h89AB;
      5'd27: s = 16'h159D;
      default: s = 16'h1456;
    endcase
    return s;
  endfunction

  // box corner plus table offsets, wraps in the index width
  function automatic tetris_pkg::cell_set_s cells_of(tetris_pkg::piece_pos_s p);
    tetris_pkg::cell_set_s cs;
    logic [15:0]           s;
    s = shape_cells(p.id, p.rot);
    for (int i = 0; i < 4; i++) begin
      cs.row[i] = p.row + tetris_pkg::row_t'(s[4*i+2 +: 2]);
      cs.col[i] = p.col + tetris_pkg::col_t'(s[4*i +: 2]);
    end
    return cs;
  endfunction

  //////////////////////////////
  // candidate and verdict
  //////////////////////////////

  tetris_pkg::piece_pos_s cand;
  tetris_pkg::cell_set_s  cand_cells;
  logic                   cand_fits;

  assign cur_cells = cells_of(cur_pos);

  // apply the requested move to the live position
  always_comb begin
    cand = cur_pos;
    case (check_code)
      `TETRIS_MV_RIGHT: cand.col = cur_pos.col + tetris_pkg::col_t'(1);
      `TETRIS_MV_LEFT:  cand.col = cur_pos.col - tetris_pkg::col_t'(1);
      `TETRIS_MV_ROR:   cand.rot = cur_pos.rot + tetris_pkg::rot_t'(1);
      `TETRIS_MV_ROL:   cand.rot = cur_pos.rot - tetris_pkg::rot_t'(1);
      `TETRIS_MV_DOWN:  cand.row = cur_pos.row + tetris_pkg::row_t'(1);
      default: cand = cur_pos;
    endcase
  end

  assign cand_cells = cells_of(cand);

  // walls and floor first, settled cells only inside the board
  always_comb begin
    cand_fits = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (cand_cells.row[i] >= `TETRIS_ROWS || cand_cells.col[i] >= `TETRIS_COLS) begin
        cand_fits = 1'b0;
      end else if (settled[cand_cells.row[i]][cand_cells.col[i]] != '0) begin
        cand_fits = 1'b0;
      end
    end
  end

  // verdict one cycle after the request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      check_done <= 1'b0;
      check_ok   <= 1'b0;
    end else begin
      check_done <= check_req;
      if (check_req) begin
        check_ok <= cand_fits;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (check_req) begin
      cand_pos <= cand;
    end
  end

endmodule

/* logic/piece_spawner.sv */
`include "tetris_config.svh"

module piece_spawner (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spawn_req,
  output tetris_pkg::piece_pos_s spawn_pos,
  output tetris_pkg::color_t     spawn_color
);

  //////////////////////////////
  // piece sequence
  //////////////////////////////

  // index of the piece handed out on the next spawn
  tetris_pkg::piece_id_t piece_idx;
  // last entry of the cycle
  logic                  idx_last;

  assign idx_last = (piece_idx == tetris_pkg::piece_id_t'(`TETRIS_PIECES - 1));

  // step only after the controller has taken the current piece
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      piece_idx <= '0;
    end else if (spawn_req) begin
      // wrap back to shape 0 after the last one
      if (idx_last) begin
        piece_idx <= '0;
      end else begin
        piece_idx <= piece_idx + tetris_pkg::piece_id_t'(1);
      end
    end
  end

  //////////////////////////////
  // spawn position
  //////////////////////////////

  // always spawn in orientation 0 at the configured corner
  always_comb begin
    spawn_pos.id  = piece_idx;
    spawn_pos.rot = '0;
    spawn_pos.row = tetris_pkg::row_t'(`TETRIS_SPAWN_ROW);
    spawn_pos.col = tetris_pkg::col_t'(`TETRIS_SPAWN_COL);
  end

  // colour k+1 for shape k, keeps zero free for empty cells
  assign spawn_color = tetris_pkg::color_t'(piece_idx) + tetris_pkg::color_t'(1);

endmodule

/* logic/tetris_pkg.sv */
`include "tetris_config.svh"

package tetris_pkg;

  //////////////////////////////
  // scalar types
  //////////////////////////////

  // row index, 0 at the top
  typedef logic [4:0] row_t;
  // column index, wraps mod 16 so one step past the left wall stays out of range
  typedef logic [3:0] col_t;
  // cell colour, zero is empty
  typedef logic [2:0] color_t;
  // shape index 0 to 6
  typedef logic [2:0] piece_id_t;
  // orientation, 1 is one clockwise step from spawn
  typedef logic [1:0] rot_t;
  // one of the TETRIS_MV_* codes
  typedef logic [2:0] move_code_t;

  // whole playfield, indexed [row][col]
  typedef color_t [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0] board_t;

  //////////////////////////////
  // grouped signals
  //////////////////////////////

  // active piece, shape plus box corner
  typedef struct packed {
    piece_id_t id;
    rot_t      rot;
    row_t      row;
    col_t      col;
  } piece_pos_s;

  // absolute board cells covered by a piece
  typedef struct packed {
    row_t [3:0] row;
    col_t [3:0] col;
  } cell_set_s;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    SPAWN,
    READY,
    RESOLVE,
    LOCK,
    CLEAR,
    GAME_OVER
  } fsm_state_e;

endpackage

/* include/tetris_config.svh */
`ifndef TETRIS_CONFIG_SVH
`define TETRIS_CONFIG_SVH

//////////////////////////////
// board geometry
//////////////////////////////

// playfield height, row 0 is the top
`define TETRIS_ROWS 20
// playfield width
`define TETRIS_COLS 10

// top left corner of the 4x4 piece box at spawn
`define TETRIS_SPAWN_ROW 0
`define TETRIS_SPAWN_COL 3

// shapes in the cyclic sequence
`define TETRIS_PIECES 7

//////////////////////////////
// move codes
//////////////////////////////

// shift one column right
`define TETRIS_MV_RIGHT 3'd0
// shift one column left
`define TETRIS_MV_LEFT 3'd1
// rotate clockwise
`define TETRIS_MV_ROR 3'd2
// rotate counter clockwise
`define TETRIS_MV_ROL 3'd3
// drop one row, locks when blocked
`define TETRIS_MV_DOWN 3'd4

`endif
